//--- trellisMonitor.f
design/trellisPkg.sv
design/trellisRegPkg.sv
design/strobeTiming.sv
design/legacyAlign.sv
design/phaseErrorLimiter.sv
design/berCounter.sv
design/regAccess.sv
design/dacMux.sv
design/trellisMonitor.sv
sim/tbTrellisMonitor.sv

//--- sim/tbTrellisMonitor.sv
/*
  Testbench for the trellis monitor.
  Clock, reset, symbol-rate stimulus, host bus transfers,
  reference model, concurrent checks, watchdog and report.
*/
module tbTrellisMonitor
  import trellisPkg::*;
  import trellisRegPkg::*;
;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int CLK_PERIOD      = 100;
  localparam int RESET_CYCLES    = 4;
  localparam int NUM_CYCLES      = 2000;
  localparam int DRAIN_CYCLES    = 20;
  localparam int TOTAL_CYCLES    = RESET_CYCLES + NUM_CYCLES + DRAIN_CYCLES;
  localparam int WATCHDOG_CYCLES = TOTAL_CYCLES + TOTAL_CYCLES / 10;
  localparam int SEED            = 59;

  logic clk, reset;
  logic symEn, sym2xEn, legacyBit, decBit, decBitEn, phErrEn, req, write;
  logic [SAMPLE_W-1:0] iIn, qIn;
  logic [PHERR_W-1:0]  phaseErr;
  logic [ADDR_W-1:0]   addr;
  dacSel_e             dac0Select, dac1Select, dac2Select;
  logic trellEna, sym2xEnOut, ack, dac0Sync, dac1Sync, dac2Sync;
  logic [DATA_W-1:0]   rdData;
  logic [SAMPLE_W-1:0] dac0Data, dac1Data, dac2Data;

  // reference model state
  logic [TRELL_DELAY-1:0] halfAge;   // half-symbol condition history
  logic [1:0]             decEnAge;
  logic                   expAck, restartDue, flipped;
  logic [PHERR_OUT_W-1:0] pendLim, curLim;
  logic [SAMPLE_W-1:0]    expIData, expQData, expPhData;
  logic                   expSyncIq, expSyncPh;
  logic [DATA_W-1:0]      expRd;
  berWord_u               berModel;
  logic                   legacyHist[$];  // one bit per symEn

  int mismatchCount = 0;
  int failureCount  = 0;
  int readCount     = 0;
  int decCount      = 0;

  trellisMonitor u_trellisMonitor (.*);

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // ----------------------------------------
  // reporting helpers
  task automatic reportMismatch(input string name, input logic [31:0] expV,
                                input logic [31:0] gotV);
    mismatchCount++;
    $display("MISMATCH time=%0t signal=%s expected=%h actual=%h", $time, name, expV, gotV);
  endtask

  task automatic reportFailure(input string what);
    failureCount++;
    $display("ERROR at %0t: %s", $time, what);
  endtask

  // symmetric clip to the signed 8-bit range
  function automatic logic [PHERR_OUT_W-1:0] clipPhase(input logic signed [PHERR_W-1:0] v);
    if (v > 127) return 8'h7f;
    if (v < -127) return 8'h81;
    return v[PHERR_OUT_W-1:0];
  endfunction

  function automatic logic [PHERR_W-1:0] pickPhaseErr();
    case ($urandom % 10)
      0: return 10'h1ff;  // +511
      1: return 10'h200;  // -512
      2: return 10'h380;  // -128, must clip
      3: return 10'h080;  // +128
      4: return 10'h07f;
      5: return 10'h381;
      default: return PHERR_W'($urandom);
    endcase
  endfunction

  // ----------------------------------------
  // reference model, all updates on the clock edge
  always @(posedge clk) begin
    if (reset) begin
      halfAge    <= '0;
      decEnAge   <= '0;
      expAck     <= 1'b0;
      restartDue <= 1'b0;
      pendLim    <= '0;
      curLim     <= '0;
      expSyncIq  <= 1'b0;
      expSyncPh  <= 1'b0;
    end else begin
      halfAge    <= {halfAge[TRELL_DELAY-2:0], sym2xEn && !symEn};
      decEnAge   <= {decEnAge[0], decBitEn};
      restartDue <= req && !expAck && write && addr == BER_ADDR;
      if (req && !expAck) expAck <= 1'b1;
      else if (!req) expAck <= 1'b0;
      if (phErrEn) begin
        pendLim <= clipPhase(phaseErr);
        curLim  <= pendLim;  // one strobe behind
      end
      expSyncIq <= sym2xEn;
      expSyncPh <= phErrEn;
    end
    expIData  <= iIn;
    expQData  <= qIn;
    expPhData <= {curLim, {(SAMPLE_W-PHERR_OUT_W){1'b0}}};
    if (req && !expAck) expRd <= (addr == BER_ADDR) ? berModel.raw : '0;
  end

  always @(posedge clk) begin
    if (reset || restartDue) begin
      berModel.count.bitCount   <= {COUNT_W{1'b1}};
      berModel.count.errorCount <= '0;
    end else if (decBitEn && berModel.count.bitCount != 0) begin
      berModel.count.bitCount <= berModel.count.bitCount - 1'b1;
      if (flipped) berModel.count.errorCount <= berModel.count.errorCount + 1'b1;
    end
  end

  // ----------------------------------------
  // checks
  assert property (@(posedge clk) $fell(reset) |->
    !(trellEna || sym2xEnOut || ack || dac0Sync || dac1Sync || dac2Sync))
    else reportFailure("control outputs were not low after reset");
  assert property (@(posedge clk) disable iff (reset) trellEna == halfAge[TRELL_DELAY-1])
    else reportMismatch("trellEna", $sampled(halfAge[TRELL_DELAY-1]), $sampled(trellEna));
  assert property (@(posedge clk) disable iff (reset) sym2xEnOut == |decEnAge)
    else reportMismatch("sym2xEnOut", $sampled(|decEnAge), $sampled(sym2xEnOut));
  assert property (@(posedge clk) disable iff (reset) ack == expAck)
    else reportMismatch("ack", $sampled(expAck), $sampled(ack));
  assert property (@(posedge clk) disable iff (reset) ack |-> rdData == expRd)
    else reportMismatch("rdData", $sampled(expRd), $sampled(rdData));
  assert property (@(posedge clk) disable iff (reset) dac0Data == expIData)
    else reportMismatch("dac0Data", $sampled(expIData), $sampled(dac0Data));
  assert property (@(posedge clk) disable iff (reset) dac0Sync == expSyncIq)
    else reportMismatch("dac0Sync", $sampled(expSyncIq), $sampled(dac0Sync));
  assert property (@(posedge clk) disable iff (reset) dac1Data == expQData)
    else reportMismatch("dac1Data", $sampled(expQData), $sampled(dac1Data));
  assert property (@(posedge clk) disable iff (reset) dac1Sync == expSyncIq)
    else reportMismatch("dac1Sync", $sampled(expSyncIq), $sampled(dac1Sync));
  assert property (@(posedge clk) disable iff (reset) dac2Data == expPhData)
    else reportMismatch("dac2Data", $sampled(expPhData), $sampled(dac2Data));
  assert property (@(posedge clk) disable iff (reset) dac2Sync == expSyncPh)
    else reportMismatch("dac2Sync", $sampled(expSyncPh), $sampled(dac2Sync));

  // ----------------------------------------
  // stimulus
  task automatic driveStrobes();
    int   decAt;
    logic legacyNow;
    logic refNow;
    logic flipNow;
    decAt = -1;
    for (int cyc = 0; cyc < NUM_CYCLES; cyc++) begin
      @(posedge clk);
      symEn    <= (cyc % 8 == 0);
      sym2xEn  <= (cyc % 4 == 0);
      phErrEn  <= (cyc % 4 == 2);
      iIn      <= SAMPLE_W'($urandom);
      qIn      <= SAMPLE_W'($urandom);
      decBitEn <= 1'b0;
      if (cyc % 8 == 0) begin
        legacyNow = $urandom % 2;
        legacyBit <= legacyNow;
        legacyHist.push_back(legacyNow);
        decAt = cyc + 2 + $urandom % 4;  // decoder latency 2 to 5
      end
      if (cyc == decAt) begin
        refNow  = (decCount < LEGACY_DELAY) ? 1'b0 : legacyHist[decCount - LEGACY_DELAY];
        flipNow = ($urandom % 4 == 0);
        decBitEn <= 1'b1;
        decBit   <= refNow ^ flipNow;
        flipped  <= flipNow;
        decCount++;
      end
      if (cyc % 4 == 2) phaseErr <= pickPhaseErr();
      // spare select code must act as phase error
      if (cyc % 512 == 256)
        dac2Select <= (dac2Select == DAC_PHERR) ? dacSel_e'(4'hb) : DAC_PHERR;
    end
    @(posedge clk);
    symEn    <= 1'b0;
    sym2xEn  <= 1'b0;
    phErrEn  <= 1'b0;
    decBitEn <= 1'b0;
  endtask

  // one four-phase transfer
  task automatic hostAccess(input logic wr, input logic [ADDR_W-1:0] a);
    @(posedge clk);
    req   <= 1'b1;
    write <= wr;
    addr  <= a;
    wait (ack);
    @(posedge clk);
    req <= 1'b0;
    wait (!ack);
    if (!wr) readCount++;
  endtask

  task automatic runHost();
    logic [ADDR_W-1:0] otherAddr;
    hostAccess(1'b1, BER_ADDR);  // restart the count
    for (int n = 0; n < 30; n++) begin
      repeat (10 + $urandom % 41) @(posedge clk);
      otherAddr = BER_ADDR + ADDR_W'(1 + $urandom % 100);
      case ($urandom % 8)
        0: hostAccess(1'b1, BER_ADDR);
        1: hostAccess(1'b0, otherAddr);
        2: hostAccess(1'b1, otherAddr);  // no effect expected
        default: hostAccess(1'b0, BER_ADDR);
      endcase
    end
  endtask

  initial begin
    void'($urandom(SEED));
    reset      = 1'b1;
    symEn      = 1'b0;
    sym2xEn    = 1'b0;
    legacyBit  = 1'b0;
    decBit     = 1'b0;
    decBitEn   = 1'b0;
    flipped    = 1'b0;
    phErrEn    = 1'b0;
    req        = 1'b0;
    write      = 1'b0;
    iIn        = '0;
    qIn        = '0;
    phaseErr   = '0;
    addr       = '0;
    dac0Select = DAC_I;
    dac1Select = DAC_Q;
    dac2Select = DAC_PHERR;
    repeat (RESET_CYCLES) @(posedge clk);
    reset <= 1'b0;
    fork
      driveStrobes();
      runHost();
    join
    repeat (DRAIN_CYCLES) @(posedge clk);
    if (readCount == 0) reportFailure("no register read completed");
    $display("errors: %0d mismatches, %0d other", mismatchCount, failureCount);
    if (mismatchCount == 0 && failureCount == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

  // watchdog, total run length plus 10 percent
  initial begin
    repeat (WATCHDOG_CYCLES) #(CLK_PERIOD);
    reportFailure("watchdog expired before the stimulus finished");
    $display("errors: %0d mismatches, %0d other", mismatchCount, failureCount);
    $display("test failed");
    $finish;
  end

endmodule

//--- design/trellisMonitor.sv
/*
  Top of the trellis decoder support logic.
  Strobe timing, legacy alignment, BER counters,
  phase error limiter, host registers and DAC mux.
*/
module trellisMonitor
  import trellisPkg::*;
  import trellisRegPkg::*;
(
  input  logic                clk,
  input  logic                reset,
  input  logic                symEn,
  input  logic                sym2xEn,
  input  logic                legacyBit,
  input  logic                decBit,
  input  logic                decBitEn,
  input  logic                phErrEn,
  input  logic                req,
  input  logic                write,
  input  logic [SAMPLE_W-1:0] iIn,
  input  logic [SAMPLE_W-1:0] qIn,
  input  logic [PHERR_W-1:0]  phaseErr,
  input  logic [ADDR_W-1:0]   addr,
  input  dacSel_e             dac0Select,
  input  dacSel_e             dac1Select,
  input  dacSel_e             dac2Select,
  output logic                trellEna,
  output logic                sym2xEnOut,
  output logic                ack,
  output logic                dac0Sync,
  output logic                dac1Sync,
  output logic                dac2Sync,
  output logic [DATA_W-1:0]   rdData,
  output logic [SAMPLE_W-1:0] dac0Data,
  output logic [SAMPLE_W-1:0] dac1Data,
  output logic [SAMPLE_W-1:0] dac2Data
);

  logic                   refBit;
  logic                   berRestart;
  logic [PHERR_OUT_W-1:0] phErrLim;
  berWord_u               berStatus;

  // ----------------------------------------
  // strobes and BER path
  strobeTiming u_strobeTiming (
    .clk        (clk),
    .reset      (reset),
    .symEn      (symEn),
    .sym2xEn    (sym2xEn),
    .decBitEn   (decBitEn),
    .trellEna   (trellEna),
    .sym2xEnOut (sym2xEnOut)
  );

  legacyAlign u_legacyAlign (
    .clk       (clk),
    .reset     (reset),
    .symEn     (symEn),
    .decBitEn  (decBitEn),
    .legacyBit (legacyBit),
    .refBit    (refBit)
  );

  berCounter u_berCounter (
    .clk        (clk),
    .reset      (reset),
    .berRestart (berRestart),
    .decBitEn   (decBitEn),
    .decBit     (decBit),
    .refBit     (refBit),
    .berStatus  (berStatus)
  );

  regAccess u_regAccess (
    .clk        (clk),
    .reset      (reset),
    .req        (req),
    .write      (write),
    .addr       (addr),
    .berStatus  (berStatus),
    .ack        (ack),
    .berRestart (berRestart),
    .rdData     (rdData)
  );

  // ----------------------------------------
  // phase error and DAC outputs
  phaseErrorLimiter u_phaseErrorLimiter (
    .clk      (clk),
    .reset    (reset),
    .phErrEn  (phErrEn),
    .phaseErr (phaseErr),
    .phErrLim (phErrLim)
  );

  dacMux u_dacMux (
    .clk        (clk),
    .reset      (reset),
    .sym2xEn    (sym2xEn),
    .phErrEn    (phErrEn),
    .iIn        (iIn),
    .qIn        (qIn),
    .phErrLim   (phErrLim),
    .dac0Select (dac0Select),
    .dac1Select (dac1Select),
    .dac2Select (dac2Select),
    .dac0Sync   (dac0Sync),
    .dac1Sync   (dac1Sync),
    .dac2Sync   (dac2Sync),
    .dac0Data   (dac0Data),
    .dac1Data   (dac1Data),
    .dac2Data   (dac2Data)
  );

endmodule

//--- design/dacMux.sv
/*
  DAC output selection.
  Three registered channels, each carrying I, Q or the
  limited phase error together with its source strobe.
*/
module dacMux
  import trellisPkg::*;
  import trellisRegPkg::*;
(
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   sym2xEn,
  input  logic                   phErrEn,
  input  logic [SAMPLE_W-1:0]    iIn,
  input  logic [SAMPLE_W-1:0]    qIn,
  input  logic [PHERR_OUT_W-1:0] phErrLim,
  input  dacSel_e                dac0Select,
  input  dacSel_e                dac1Select,
  input  dacSel_e                dac2Select,
  output logic                   dac0Sync,
  output logic                   dac1Sync,
  output logic                   dac2Sync,
  output logic [SAMPLE_W-1:0]    dac0Data,
  output logic [SAMPLE_W-1:0]    dac1Data,
  output logic [SAMPLE_W-1:0]    dac2Data
);

  logic [SAMPLE_W-1:0] phErrWord;
  logic [SAMPLE_W:0]   src0;  // {sync, data}
  logic [SAMPLE_W:0]   src1;
  logic [SAMPLE_W:0]   src2;

  // phase error left aligned on the DAC
  assign phErrWord = {phErrLim, {(SAMPLE_W-PHERR_OUT_W){1'b0}}};

  function automatic logic [SAMPLE_W:0] dacSource(
    input dacSel_e             sel,
    input logic                iqSync,
    input logic [SAMPLE_W-1:0] iWord,
    input logic [SAMPLE_W-1:0] qWord,
    input logic                phSync,
    input logic [SAMPLE_W-1:0] phWord
  );
    case (sel)
      DAC_I:   dacSource = {iqSync, iWord};
      DAC_Q:   dacSource = {iqSync, qWord};
      default: dacSource = {phSync, phWord};  // DAC_PHERR and spare codes
    endcase
  endfunction

  assign src0 = dacSource(dac0Select, sym2xEn, iIn, qIn, phErrEn, phErrWord);
  assign src1 = dacSource(dac1Select, sym2xEn, iIn, qIn, phErrEn, phErrWord);
  assign src2 = dacSource(dac2Select, sym2xEn, iIn, qIn, phErrEn, phErrWord);

  // ----------------------------------------
  // one register stage on every channel
  always_ff @(posedge clk) begin
    if (reset) begin
      dac0Sync <= 1'b0;
      dac1Sync <= 1'b0;
      dac2Sync <= 1'b0;
    end else begin
      dac0Sync <= src0[SAMPLE_W];
      dac1Sync <= src1[SAMPLE_W];
      dac2Sync <= src2[SAMPLE_W];
    end
  end

  always_ff @(posedge clk) begin
    dac0Data <= src0[SAMPLE_W-1:0];
    dac1Data <= src1[SAMPLE_W-1:0];
    dac2Data <= src2[SAMPLE_W-1:0];
  end

endmodule

//--- design/regAccess.sv
/*
  Host register port.
  Four-phase req/ack handshake, BER address decode,
  read data capture and the BER restart pulse.
*/
module regAccess
  import trellisPkg::*;
  import trellisRegPkg::*;
(
  input  logic              clk,
  input  logic              reset,
  input  logic              req,
  input  logic              write,
  input  logic [ADDR_W-1:0] addr,
  input  berWord_u          berStatus,
  output logic              ack,
  output logic              berRestart,
  output logic [DATA_W-1:0] rdData
);

  logic berHit;
  logic ackRise;

  assign berHit  = addr == BER_ADDR;
  assign ackRise = req && !ack;  // new request after the last ack has dropped

  // ----------------------------------------
  // handshake state
  always_ff @(posedge clk) begin
    if (reset) begin
      ack        <= 1'b0;
      berRestart <= 1'b0;
    end else begin
      berRestart <= ackRise && write && berHit;  // single cycle
      if (ackRise) begin
        ack <= 1'b1;
      end else if (!req) begin
        ack <= 1'b0;
      end
    end
  end

  // read data held while ack is high
  always_ff @(posedge clk) begin
    if (ackRise) begin
      rdData <= berHit ? berStatus.raw : '0;  // unmapped reads as zero
    end
  end

  // host must keep req up until it sees ack
  assert property (@(posedge clk) disable iff (reset)
    $rose(ack) |-> req);

endmodule

//--- design/berCounter.sv
/*
  Bit error estimate.
  Down-counter of compared bits and up-counter of mismatches
  against the aligned legacy bit, restarted by the host.
*/
module berCounter
  import trellisPkg::*;
  import trellisRegPkg::*;
(
  input  logic     clk,
  input  logic     reset,
  input  logic     berRestart,
  input  logic     decBitEn,
  input  logic     decBit,
  input  logic     refBit,
  output berWord_u berStatus
);

  logic countDone;

  assign countDone = berStatus.count.bitCount == '0;  // window used up

  // ----------------------------------------
  // one compare per decoded bit until the window is spent
  always_ff @(posedge clk) begin
    if (reset || berRestart) begin
      berStatus.count.bitCount   <= {COUNT_W{1'b1}};
      berStatus.count.errorCount <= '0;
    end else if (decBitEn && !countDone) begin
      berStatus.count.bitCount <= berStatus.count.bitCount - 1'b1;
      if (decBit != refBit) begin
        berStatus.count.errorCount <= berStatus.count.errorCount + 1'b1;
      end
    end
  end

  // window only refills on restart
  assert property (@(posedge clk) disable iff (reset)
    !berRestart |=> berStatus.count.bitCount <= $past(berStatus.count.bitCount));

endmodule

//--- design/phaseErrorLimiter.sv
/*
  Phase error limiter.
  Clips the decoder phase error to a signed 8-bit value,
  one strobe of pipeline between input and output.
*/
module phaseErrorLimiter
  import trellisPkg::*;
(
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   phErrEn,
  input  logic [PHERR_W-1:0]     phaseErr,
  output logic [PHERR_OUT_W-1:0] phErrLim
);

  logic signed [PHERR_W-1:0] errSigned;
  logic [PHERR_OUT_W-1:0]    dataBits;
  logic                      satPos;
  logic                      satNeg;

  assign errSigned = phaseErr;

  // first stage keeps low bits and overflow flags,
  // second stage picks the output at the next strobe
  always_ff @(posedge clk) begin
    if (reset) begin
      dataBits <= '0;
      satPos   <= 1'b0;
      satNeg   <= 1'b0;
      phErrLim <= '0;
    end else if (phErrEn) begin
      dataBits <= phaseErr[PHERR_OUT_W-1:0];
      satPos   <= errSigned > PHERR_MAX;
      satNeg   <= errSigned < PHERR_MIN;  // -128 counts as overflow
      if (satPos) begin
        phErrLim <= PHERR_MAX;
      end else if (satNeg) begin
        phErrLim <= PHERR_MIN;
      end else begin
        phErrLim <= dataBits;
      end
    end
  end

  // clip is symmetric around zero
  assert property (@(posedge clk) disable iff (reset)
    phErrLim != {1'b1, {(PHERR_OUT_W-1){1'b0}}});

endmodule

//--- design/legacyAlign.sv
/*
  Legacy reference bit alignment.
  Symbol-rate delay line for the legacy bit and a bit FIFO
  that hands one reference bit to each decoder output strobe.
*/
module legacyAlign
  import trellisPkg::*;
(
  input  logic clk,
  input  logic reset,
  input  logic symEn,
  input  logic decBitEn,
  input  logic legacyBit,
  output logic refBit
);

  logic [LEGACY_DELAY-1:0] legacySr;
  logic                    alignMem [ALIGN_DEPTH];
  logic [ALIGN_PTR_W-1:0]  wrPtr;
  logic [ALIGN_PTR_W-1:0]  rdPtr;
  logic [ALIGN_PTR_W:0]    fillCount;  // needs one extra bit for full

  // ----------------------------------------
  // delay line, cleared so the first pushes are zero
  always_ff @(posedge clk) begin
    if (reset) begin
      legacySr <= '0;
    end else if (symEn) begin
      legacySr <= {legacySr[LEGACY_DELAY-2:0], legacyBit};
    end
  end

  // ----------------------------------------
  // alignment FIFO, push on symEn and pop on decBitEn
  always_ff @(posedge clk) begin
    if (symEn) begin
      alignMem[wrPtr] <= legacySr[LEGACY_DELAY-1];
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      wrPtr     <= '0;
      rdPtr     <= '0;
      fillCount <= '0;
    end else begin
      if (symEn) wrPtr <= wrPtr + 1'b1;      // wraps at depth
      if (decBitEn) rdPtr <= rdPtr + 1'b1;
      case ({symEn, decBitEn})
        2'b10:   fillCount <= fillCount + 1'b1;
        2'b01:   fillCount <= fillCount - 1'b1;
        default: fillCount <= fillCount;
      endcase
    end
  end

  assign refBit = alignMem[rdPtr];  // valid in the decBitEn cycle

  // decoder latency must stay inside the FIFO depth
  assert property (@(posedge clk) disable iff (reset)
    symEn |-> fillCount != ALIGN_DEPTH);
  assert property (@(posedge clk) disable iff (reset)
    decBitEn |-> fillCount != 0);

endmodule

//--- design/strobeTiming.sv
/*
  Strobe timing around the decoder.
  Decoder enable from the half-symbol condition and
  the two-cycle double-rate strobe for the line decoder.
*/
module strobeTiming
  import trellisPkg::*;
(
  input  logic clk,
  input  logic reset,
  input  logic symEn,
  input  logic sym2xEn,
  input  logic decBitEn,
  output logic trellEna,
  output logic sym2xEnOut
);

  logic [TRELL_DELAY-1:0] halfSymShift;  // one bit per cycle of delay
  logic                   decBitDly;

  // second half of the symbol is sym2xEn without symEn
  always_ff @(posedge clk) begin
    if (reset) begin
      halfSymShift <= '0;
    end else begin
      halfSymShift <= {halfSymShift[TRELL_DELAY-2:0], sym2xEn & ~symEn};
    end
  end

  assign trellEna = halfSymShift[TRELL_DELAY-1];

  // widen each decoded bit strobe to two cycles
  always_ff @(posedge clk) begin
    if (reset) begin
      decBitDly  <= 1'b0;
      sym2xEnOut <= 1'b0;
    end else begin
      decBitDly  <= decBitEn;
      sym2xEnOut <= decBitEn | decBitDly;  // high 1 and 2 cycles later
    end
  end

  // two-cycle widening only works with at least 3 cycles between strobes
  assert property (@(posedge clk) disable iff (reset)
    decBitEn |=> !decBitEn [*2]);

endmodule

//--- design/trellisRegPkg.sv
/*
  Host-visible definitions.
  Bus widths, register map, DAC source codes
  and the BER status word with its two views.
*/
package trellisRegPkg;

  import trellisPkg::*;

  // ----------------------------------------
  // host bus
  localparam int ADDR_W = 12;
  localparam int DATA_W = 32;

  // register map, one word only
  localparam logic [ADDR_W-1:0] BER_ADDR = 12'h040;

  // ----------------------------------------
  // DAC source select, unlisted codes fall back to phase error
  typedef enum logic [3:0] {
    DAC_I     = 4'h0,
    DAC_Q     = 4'h1,
    DAC_PHERR = 4'h2
  } dacSel_e;

  // BER status word
  // raw is what the host reads, count is how the counter fills it
  typedef struct packed {
    logic [COUNT_W-1:0] errorCount;  // upper half
    logic [COUNT_W-1:0] bitCount;    // lower half, counts down
  } berCount_t;

  typedef union packed {
    logic [DATA_W-1:0] raw;
    berCount_t         count;
  } berWord_u;

endpackage

//--- design/trellisPkg.sv
/*
  Datapath constants for the trellis monitor.
  Sample and phase error widths, clip limits, strobe delays,
  alignment FIFO depth and BER counter width.
*/
package trellisPkg;

  // ----------------------------------------
  // sample and phase error widths
  localparam int SAMPLE_W    = 18;  // I/Q samples and DAC words
  localparam int PHERR_W     = 10;  // raw phase error from the decoder
  localparam int PHERR_OUT_W = 8;   // after limiting

  // symmetric clip, -128 is never produced
  localparam logic signed [PHERR_OUT_W-1:0] PHERR_MAX = 8'sd127;
  localparam logic signed [PHERR_OUT_W-1:0] PHERR_MIN = -8'sd127;

  // ----------------------------------------
  // strobe timing and BER alignment
  localparam int TRELL_DELAY  = 11;  // half-symbol condition to decoder enable
  localparam int LEGACY_DELAY = 14;  // in symbol strobes
  localparam int ALIGN_DEPTH  = 32;
  localparam int ALIGN_PTR_W  = $clog2(ALIGN_DEPTH);
  localparam int COUNT_W      = 16;  // each BER counter

endpackage
